/* sim.f */
+incdir+bench
logic/frame_timing_pkg.sv
logic/slot_timing_if.sv
logic/frame_align.sv
logic/symbol_timer.sv
logic/sub_tick_gen.sv
logic/timing_out_stage.sv
logic/frame_timing_gen.sv
bench/tb_frame_timing.sv

/* Bender.yml */
package:
  name: frame_timing_gen

sources:
  - logic/frame_timing_pkg.sv
  - logic/slot_timing_if.sv
  - logic/frame_align.sv
  - logic/symbol_timer.sv
  - logic/sub_tick_gen.sv
  - logic/timing_out_stage.sv
  - logic/frame_timing_gen.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_frame_timing.sv

/* bench/tb_frame_timing_tasks.svh */
`ifndef TB_FRAME_TIMING_TASKS_SVH
`define TB_FRAME_TIMING_TASKS_SVH

// ----------------------------------------------------------
// reference model
// ----------------------------------------------------------

// long cp on the first and the middle symbol of a subframe
function automatic int symbol_length(input int k);
	int sf_symbs;
	int pos_in_sf;
	sf_symbs = SLOTS_PER_SUBFRAME * frame_timing_pkg::SYMB_PER_SLOT;
	pos_in_sf = k % sf_symbs;
	if ((pos_in_sf == 0) || (pos_in_sf == sf_symbs / 2))
		return FFT_LEN + CP_LONG;
	return FFT_LEN + CP_NORMAL;
endfunction

// gap before tick idx, short one opens each group of five
function automatic int tick_gap(input int idx);
	return (((idx - 1) % 5) == 0) ? TICK_LESS : TICK_MORE;
endfunction

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (act === exp)
	else
	begin
		$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		$display("=== FAIL ===");
		$fatal(1, "mismatch on %s", name);
	end
endtask

// ----------------------------------------------------------
// directed tests
// ----------------------------------------------------------

// nothing may pulse before the first frame start
task automatic idle_after_reset(input int cycles);
	repeat (cycles)
	begin
		@(negedge clk);
		check_val("o_frame_head", 0, frame_head);
		check_val("o_half_frame_head", 0, half_frame_head);
		check_val("o_slot_head", 0, slot_head);
		check_val("o_symb_head", 0, symb_head);
		check_val("o_tick_vld", 0, tick_vld);
	end
endtask

// find the sampling edge of pos, head is due 3 cycles later
task automatic wait_frame_pos(input int pos);
	@(posedge clk);
	while (int'(ref_frame_cnt) != pos)
		@(posedge clk);
	repeat (3)
	begin
		@(negedge clk);
		check_val("o_frame_head", 0, frame_head);
	end
endtask

// one whole frame, every head checked on every cycle
task automatic run_frame();
	int symb_at;
	int k;
	int tick_at;
	int tick_idx;
	logic exp_symb;
	logic exp_slot;
	logic exp_hhead;
	logic exp_tick;
	symb_at = 0;
	k = 0;
	tick_at = -1;
	tick_idx = 0;
	for (int c = 0; c < FRAME_LEN; c++)
	begin
		@(negedge clk);
		exp_symb = (c == symb_at);
		exp_slot = exp_symb && ((k % frame_timing_pkg::SYMB_PER_SLOT) == 0);
		exp_hhead = (c == 0) || (c == HALF_LEN);
		exp_tick = (c == tick_at);
		check_val("o_frame_head", c == 0, frame_head);
		check_val("o_half_frame_head", exp_hhead, half_frame_head);
		check_val("o_symb_head", exp_symb, symb_head);
		check_val("o_slot_head", exp_slot, slot_head);
		check_val("o_tick_vld", exp_tick, tick_vld);
		if (c == 0)
			check_val("o_frame_num", exp_frame, frame_num);
		if (exp_hhead)
		begin
			check_val("o_half_frame_num", exp_half, half_frame_num);
			exp_half++;
		end
		// tick chain ends at the last index of the slot
		if (exp_tick)
		begin
			check_val("o_tick_num", tick_idx, tick_num);
			if (tick_idx == TICKS_PER_SLOT - 1)
				tick_at = -1;
			else
			begin
				tick_idx++;
				tick_at = c + tick_gap(tick_idx);
			end
		end
		// slot start, first tick one cycle behind
		if (exp_slot)
		begin
			check_val("o_slot_num", k / frame_timing_pkg::SYMB_PER_SLOT, slot_num);
			tick_idx = 0;
			tick_at = c + 1;
		end
		if (exp_symb)
		begin
			check_val("o_symb_num", k % frame_timing_pkg::SYMB_PER_SLOT, symb_num);
			symb_at += symbol_length(k);
			k++;
		end
	end
	exp_frame++;
endtask

// new position a random number of slots ahead, cuts the running frame
task automatic realign_frame(input int old_pos);
	int slots;
	int offset;
	int new_pos;
	slots = 1 + int'($urandom % 7);
	offset = 0;
	for (int k = 0; k < slots * frame_timing_pkg::SYMB_PER_SLOT; k++)
		offset += symbol_length(k);
	new_pos = (old_pos + offset) % FRAME_LEN;
	set_frame_pos = frame_timing_pkg::smp_cnt_t'(new_pos);

	// frame already in flight from the old position
	@(negedge clk);
	check_val("o_frame_head", 1, frame_head);
	check_val("o_frame_num", exp_frame, frame_num);
	check_val("o_half_frame_head", 1, half_frame_head);
	check_val("o_half_frame_num", exp_half, half_frame_num);
	exp_frame++;
	exp_half++;

	wait_frame_pos(new_pos);
	run_frame();
endtask

`endif

/* bench/tb_frame_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frame_timing;

	// ----------------------------------------------------------
	// bench numerology, small enough to run whole frames
	// ----------------------------------------------------------

	localparam int FFT_LEN = 8;
	localparam int CP_NORMAL = 1;
	localparam int CP_LONG = 3;
	localparam int SLOTS_PER_FRAME = 16;
	localparam int SLOTS_PER_SUBFRAME = 4;
	localparam int TICK_LESS = 4;
	localparam int TICK_MORE = 5;
	localparam int TICKS_PER_SLOT = 25;

	// sum of all symbol lengths in one frame for these values
	localparam int FRAME_LEN = 2032;
	localparam int HALF_LEN = FRAME_LEN / 2;

	// first alignment point, well past the idle window
	localparam int FIRST_POS = 600;
	localparam int SEED = 35363;

	// about six frames plus margin
	localparam int MAX_CYCLES = 14000;

	logic clk;
	logic rst;
	frame_timing_pkg::smp_cnt_t ref_frame_cnt;
	frame_timing_pkg::smp_cnt_t set_frame_pos;

	frame_timing_pkg::half_frame_num_t half_frame_num;
	frame_timing_pkg::frame_num_t frame_num;
	frame_timing_pkg::slot_num_t slot_num;
	frame_timing_pkg::symb_num_t symb_num;
	frame_timing_pkg::tick_num_t tick_num;
	logic half_frame_head;
	logic frame_head;
	logic slot_head;
	logic symb_head;
	logic tick_vld;

	// running expectations, shared by the test tasks
	int exp_frame;
	int exp_half;
	int cycle_cnt = 0;
	int seed_val;

	// 4 ns clock
	always #2 clk = ~clk;

	// reference counter, one step per sample
	always @(negedge clk)
	begin
		ref_frame_cnt <= frame_timing_pkg::smp_cnt_t'((int'(ref_frame_cnt) + 1) % FRAME_LEN);
	end

	// hang guard
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "cycle limit reached");
		end
	end

	frame_timing_gen #(
		.FFT_LEN            (FFT_LEN),
		.CP_NORMAL          (CP_NORMAL),
		.CP_LONG            (CP_LONG),
		.SLOTS_PER_FRAME    (SLOTS_PER_FRAME),
		.SLOTS_PER_SUBFRAME (SLOTS_PER_SUBFRAME),
		.TICK_LESS          (TICK_LESS),
		.TICK_MORE          (TICK_MORE),
		.TICKS_PER_SLOT     (TICKS_PER_SLOT)
	) uut (
		.clk               (clk),
		.rst               (rst),
		.i_ref_frame_cnt   (ref_frame_cnt),
		.i_set_frame_pos   (set_frame_pos),
		.o_half_frame_num  (half_frame_num),
		.o_frame_num       (frame_num),
		.o_slot_num        (slot_num),
		.o_symb_num        (symb_num),
		.o_half_frame_head (half_frame_head),
		.o_frame_head      (frame_head),
		.o_slot_head       (slot_head),
		.o_symb_head       (symb_head),
		.o_tick_num        (tick_num),
		.o_tick_vld        (tick_vld)
	);

	`include "tb_frame_timing_tasks.svh"

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		ref_frame_cnt = '0;
		set_frame_pos = frame_timing_pkg::smp_cnt_t'(FIRST_POS);
		exp_frame = 0;
		exp_half = 0;
		seed_val = $urandom(SEED);

		// 10 cycles of reset
		repeat (10) @(negedge clk);
		rst = 1'b0;

		idle_after_reset(200);

		// frames 0, 1, 2 back to back
		wait_frame_pos(FIRST_POS);
		run_frame();
		run_frame();
		run_frame();

		// jump to a new position, numbering must follow
		realign_frame(FIRST_POS);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/frame_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_timing_gen #(
	// defaults: 491.52 MHz, 10 ms frame, 125 us slot, 5 us ticks
	parameter int FFT_LEN = 4096,
	parameter int CP_NORMAL = 288,
	parameter int CP_LONG = 544,
	parameter int SLOTS_PER_FRAME = 80,
	parameter int SLOTS_PER_SUBFRAME = 8,
	parameter int TICK_LESS = 2456,
	parameter int TICK_MORE = 2458,
	parameter int TICKS_PER_SLOT = 25
) (
	input wire clk,
	input wire rst,
	input wire frame_timing_pkg::smp_cnt_t i_ref_frame_cnt,
	input wire frame_timing_pkg::smp_cnt_t i_set_frame_pos,
	output wire frame_timing_pkg::half_frame_num_t o_half_frame_num,
	output wire frame_timing_pkg::frame_num_t o_frame_num,
	output wire frame_timing_pkg::slot_num_t o_slot_num,
	output wire frame_timing_pkg::symb_num_t o_symb_num,
	output wire o_half_frame_head,
	output wire o_frame_head,
	output wire o_slot_head,
	output wire o_symb_head,
	output wire frame_timing_pkg::tick_num_t o_tick_num,
	output wire o_tick_vld
);

	// all normal symbols plus the extra cp of two long ones per subframe
	localparam int FRAME_LEN =
		SLOTS_PER_FRAME * frame_timing_pkg::SYMB_PER_SLOT * (FFT_LEN + CP_NORMAL) +
		2 * (SLOTS_PER_FRAME / SLOTS_PER_SUBFRAME) * (CP_LONG - CP_NORMAL);
	localparam int HALF_LEN = FRAME_LEN / 2;

	wire frame_start;
	wire half_start;
	wire tick;
	wire frame_timing_pkg::tick_num_t tick_num;

	slot_timing_if tim_if ();

	// ----------------------------------------------------------
	// alignment to the reference counter
	// ----------------------------------------------------------

	frame_align #(
		.FRAME_LEN (FRAME_LEN),
		.HALF_LEN  (HALF_LEN)
	) u_align (
		.clk           (clk),
		.rst           (rst),
		.i_ref_cnt     (i_ref_frame_cnt),
		.i_frame_pos   (i_set_frame_pos),
		.o_frame_start (frame_start),
		.o_half_start  (half_start)
	);

	// symbols and slots
	symbol_timer #(
		.FFT_LEN            (FFT_LEN),
		.CP_NORMAL          (CP_NORMAL),
		.CP_LONG            (CP_LONG),
		.SLOTS_PER_FRAME    (SLOTS_PER_FRAME),
		.SLOTS_PER_SUBFRAME (SLOTS_PER_SUBFRAME)
	) u_symb (
		.clk           (clk),
		.rst           (rst),
		.i_frame_start (frame_start),
		.o_tim         (tim_if.src)
	);

	// 5 us grid inside each slot
	sub_tick_gen #(
		.TICK_LESS      (TICK_LESS),
		.TICK_MORE      (TICK_MORE),
		.TICKS_PER_SLOT (TICKS_PER_SLOT)
	) u_tick (
		.clk        (clk),
		.rst        (rst),
		.i_tim      (tim_if.tick),
		.o_tick     (tick),
		.o_tick_num (tick_num)
	);

	// ----------------------------------------------------------
	// counters and output register
	// ----------------------------------------------------------

	timing_out_stage u_out (
		.clk               (clk),
		.rst               (rst),
		.i_half_start      (half_start),
		.i_tick            (tick),
		.i_tick_num        (tick_num),
		.i_tim             (tim_if.out),
		.o_half_frame_num  (o_half_frame_num),
		.o_frame_num       (o_frame_num),
		.o_slot_num        (o_slot_num),
		.o_symb_num        (o_symb_num),
		.o_half_frame_head (o_half_frame_head),
		.o_frame_head      (o_frame_head),
		.o_slot_head       (o_slot_head),
		.o_symb_head       (o_symb_head),
		.o_tick_num        (o_tick_num),
		.o_tick_vld        (o_tick_vld)
	);

endmodule

`default_nettype wire

/* logic/timing_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module timing_out_stage (
	input wire clk,
	input wire rst,
	input wire i_half_start,
	input wire i_tick,
	input wire frame_timing_pkg::tick_num_t i_tick_num,
	slot_timing_if.out i_tim,
	output frame_timing_pkg::half_frame_num_t o_half_frame_num,
	output frame_timing_pkg::frame_num_t o_frame_num,
	output frame_timing_pkg::slot_num_t o_slot_num,
	output frame_timing_pkg::symb_num_t o_symb_num,
	output logic o_half_frame_head,
	output logic o_frame_head,
	output logic o_slot_head,
	output logic o_symb_head,
	output frame_timing_pkg::tick_num_t o_tick_num,
	output logic o_tick_vld
);

	logic half_q;
	frame_timing_pkg::frame_num_t frame_cnt;
	frame_timing_pkg::frame_num_t frame_nxt;
	frame_timing_pkg::half_frame_num_t half_cnt;
	frame_timing_pkg::half_frame_num_t half_nxt;

	// half start delayed to line up with frame_start_q
	always_ff @(posedge clk)
	begin
		if (rst)
			half_q <= 1'b0;
		else
			half_q <= i_half_start;
	end

	// ----------------------------------------------------------
	// frame and half-frame counters
	// ----------------------------------------------------------

	// next value goes to the output so number and head match
	assign frame_nxt = i_tim.frame_start_q ?
		frame_cnt + frame_timing_pkg::frame_num_t'(1) : frame_cnt;
	assign half_nxt = half_q ?
		half_cnt + frame_timing_pkg::half_frame_num_t'(1) : half_cnt;

	// all ones after reset so the first start reads 0
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			frame_cnt <= '1;
			half_cnt <= '1;
		end
		else
		begin
			frame_cnt <= frame_nxt;
			half_cnt <= half_nxt;
		end
	end

	// ----------------------------------------------------------
	// output register
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_half_frame_head <= 1'b0;
			o_frame_head <= 1'b0;
			o_slot_head <= 1'b0;
			o_symb_head <= 1'b0;
			o_tick_vld <= 1'b0;
		end
		else
		begin
			o_half_frame_head <= half_q;
			o_frame_head <= i_tim.frame_start_q;
			// frame start restarts slot and symbol too
			o_slot_head <= i_tim.slot_head | i_tim.frame_start_q;
			o_symb_head <= i_tim.symb_head | i_tim.frame_start_q;
			o_tick_vld <= i_tick;
		end
	end

	// numbers registered alongside their heads
	always_ff @(posedge clk)
	begin
		o_half_frame_num <= half_nxt;
		o_frame_num <= frame_nxt;
		o_slot_num <= i_tim.slot_num;
		o_symb_num <= i_tim.symb_num;
		o_tick_num <= i_tick_num;
	end

endmodule

`default_nettype wire

/* logic/sub_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_tick_gen #(
	parameter int TICK_LESS = 2456,
	parameter int TICK_MORE = 2458,
	parameter int TICKS_PER_SLOT = 25
) (
	input wire clk,
	input wire rst,
	slot_timing_if.tick i_tim,
	output logic o_tick,
	output frame_timing_pkg::tick_num_t o_tick_num
);

	// one short period then four long ones
	localparam int PHASES = 5;
	localparam frame_timing_pkg::tick_num_t LAST_TICK =
		frame_timing_pkg::tick_num_t'(TICKS_PER_SLOT - 1);

	logic active;
	logic slot_start;
	logic counting;
	logic per_done;
	logic [2:0] phase;
	frame_timing_pkg::symb_len_t per_cnt;
	frame_timing_pkg::symb_len_t per_len;

	// a frame restart is a slot start too
	assign slot_start = i_tim.slot_head | i_tim.frame_start_q;

	// stop after the last tick of the slot
	assign counting = active && (o_tick_num != LAST_TICK);

	assign per_len = (phase == '0) ?
		frame_timing_pkg::symb_len_t'(TICK_LESS) :
		frame_timing_pkg::symb_len_t'(TICK_MORE);
	assign per_done = counting && (per_cnt == per_len);

	// ----------------------------------------------------------
	// fractional divider
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			active <= 1'b0;
		else if (slot_start)
			active <= 1'b1;
	end

	// period counter, cycle of the tick counts as 1
	always_ff @(posedge clk)
	begin
		if (rst)
			per_cnt <= '0;
		else if (slot_start || per_done)
			per_cnt <= frame_timing_pkg::symb_len_t'(1);
		else if (counting)
			per_cnt <= per_cnt + frame_timing_pkg::symb_len_t'(1);
	end

	// 5-phase cycle index picks the period length
	always_ff @(posedge clk)
	begin
		if (rst || slot_start)
			phase <= '0;
		else if (per_done)
			phase <= (phase == 3'(PHASES - 1)) ? '0 : phase + 3'd1;
	end

	// ----------------------------------------------------------
	// tick pulse and index
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_tick <= 1'b0;
			o_tick_num <= '0;
		end
		else
		begin
			o_tick <= slot_start || per_done;
			if (slot_start)
				o_tick_num <= '0;
			else if (per_done)
				o_tick_num <= o_tick_num + frame_timing_pkg::tick_num_t'(1);
		end
	end

	a_tick_range : assert property (
		@(posedge clk) disable iff (rst) o_tick_num <= LAST_TICK
	);

endmodule

`default_nettype wire

/* logic/symbol_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_timer #(
	parameter int FFT_LEN = 4096,
	parameter int CP_NORMAL = 288,
	parameter int CP_LONG = 544,
	parameter int SLOTS_PER_FRAME = 80,
	parameter int SLOTS_PER_SUBFRAME = 8
) (
	input wire clk,
	input wire rst,
	input wire i_frame_start,
	slot_timing_if.src o_tim
);

	// symbols in one subframe, two of them carry the long cp
	localparam int SF_SYMBS = SLOTS_PER_SUBFRAME * frame_timing_pkg::SYMB_PER_SLOT;
	localparam int SF_W = $clog2(SF_SYMBS);

	localparam frame_timing_pkg::symb_len_t LEN_NORMAL =
		frame_timing_pkg::symb_len_t'(FFT_LEN + CP_NORMAL);
	localparam frame_timing_pkg::symb_len_t LEN_LONG =
		frame_timing_pkg::symb_len_t'(FFT_LEN + CP_LONG);
	localparam frame_timing_pkg::symb_num_t LAST_SYMB =
		frame_timing_pkg::symb_num_t'(frame_timing_pkg::SYMB_PER_SLOT - 1);
	localparam frame_timing_pkg::slot_num_t LAST_SLOT =
		frame_timing_pkg::slot_num_t'(SLOTS_PER_FRAME - 1);

	logic running;
	logic [SF_W-1:0] sf_symb;
	frame_timing_pkg::symb_len_t symb_cnt;
	frame_timing_pkg::symb_len_t symb_len;
	frame_timing_pkg::symb_num_t symb_num;
	frame_timing_pkg::slot_num_t slot_num;
	logic symb_end;
	logic slot_end;
	logic symb_head;
	logic slot_head;
	logic frame_start_q;

	// long cp on symbol 0 and the middle symbol of each subframe
	assign symb_len = ((sf_symb == '0) || (sf_symb == SF_W'(SF_SYMBS / 2))) ?
		LEN_LONG : LEN_NORMAL;

	// last sample of the current symbol / slot
	assign symb_end = running && (symb_cnt == symb_len);
	assign slot_end = symb_end && (symb_num == LAST_SYMB);

	// ----------------------------------------------------------
	// sample counter
	// ----------------------------------------------------------

	// nothing runs before the first frame start
	always_ff @(posedge clk)
	begin
		if (rst)
			running <= 1'b0;
		else if (i_frame_start)
			running <= 1'b1;
	end

	// samples numbered 1..len, so a restart lands on sample 1
	always_ff @(posedge clk)
	begin
		if (rst)
			symb_cnt <= '0;
		else if (i_frame_start || symb_end)
			symb_cnt <= frame_timing_pkg::symb_len_t'(1);
		else if (running)
			symb_cnt <= symb_cnt + frame_timing_pkg::symb_len_t'(1);
	end

	// symbol index inside the subframe, only drives cp choice
	always_ff @(posedge clk)
	begin
		if (rst || i_frame_start)
			sf_symb <= '0;
		else if (symb_end)
			sf_symb <= (sf_symb == SF_W'(SF_SYMBS - 1)) ? '0 : sf_symb + SF_W'(1);
	end

	// ----------------------------------------------------------
	// symbol and slot numbering
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst || i_frame_start)
		begin
			symb_num <= '0;
			slot_num <= '0;
		end
		else if (symb_end)
		begin
			symb_num <= slot_end ? '0 : symb_num + frame_timing_pkg::symb_num_t'(1);
			if (slot_end)
				slot_num <= (slot_num == LAST_SLOT) ? '0 :
					slot_num + frame_timing_pkg::slot_num_t'(1);
		end
	end

	// heads land on sample 1, same cycle as the new numbers
	// frame start wins, it is signalled through frame_start_q
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			symb_head <= 1'b0;
			slot_head <= 1'b0;
			frame_start_q <= 1'b0;
		end
		else
		begin
			symb_head <= symb_end && !i_frame_start;
			slot_head <= slot_end && !i_frame_start;
			frame_start_q <= i_frame_start;
		end
	end

	assign o_tim.symb_head = symb_head;
	assign o_tim.slot_head = slot_head;
	assign o_tim.symb_num = symb_num;
	assign o_tim.slot_num = slot_num;
	assign o_tim.frame_start_q = frame_start_q;

	a_symb_range : assert property (
		@(posedge clk) disable iff (rst) int'(symb_num) < frame_timing_pkg::SYMB_PER_SLOT
	);

	a_slot_range : assert property (
		@(posedge clk) disable iff (rst) int'(slot_num) < SLOTS_PER_FRAME
	);

endmodule

`default_nettype wire

/* logic/frame_align.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_align #(
	parameter int FRAME_LEN = 4915200,
	parameter int HALF_LEN = 2457600
) (
	input wire clk,
	input wire rst,
	input wire frame_timing_pkg::smp_cnt_t i_ref_cnt,
	input wire frame_timing_pkg::smp_cnt_t i_frame_pos,
	output logic o_frame_start,
	output logic o_half_start
);

	// one extra bit so the mid-frame sum cannot overflow
	localparam int SUM_W = $bits(frame_timing_pkg::smp_cnt_t) + 1;

	frame_timing_pkg::smp_cnt_t ref_q;
	frame_timing_pkg::smp_cnt_t ref_prev;
	frame_timing_pkg::smp_cnt_t mid_pos;
	logic [SUM_W-1:0] mid_sum;
	logic ref_step;
	logic hit_frame;
	logic hit_mid;

	// ----------------------------------------------------------
	// reference sampling
	// ----------------------------------------------------------

	// ref_q holds the sampled value and ref_prev the one before
	always_ff @(posedge clk)
	begin
		ref_q <= i_ref_cnt;
		ref_prev <= ref_q;
	end

	// only act when the reference steps
	assign ref_step = (ref_q != ref_prev);

	// mid-frame position wrapped into the frame
	assign mid_sum = SUM_W'(i_frame_pos) + SUM_W'(HALF_LEN);
	assign mid_pos = (mid_sum >= SUM_W'(FRAME_LEN)) ?
		frame_timing_pkg::smp_cnt_t'(mid_sum - SUM_W'(FRAME_LEN)) :
		frame_timing_pkg::smp_cnt_t'(mid_sum);

	assign hit_frame = ref_step && (ref_q == i_frame_pos);
	assign hit_mid = ref_step && (ref_q == mid_pos);

	// ----------------------------------------------------------
	// start pulses
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_frame_start <= 1'b0;
			o_half_start <= 1'b0;
		end
		else
		begin
			o_frame_start <= hit_frame;
			// a frame start is also the first half
			o_half_start <= hit_frame || hit_mid;
		end
	end

	// set position outside the frame never meets the reference
	a_pos_in_frame : assert property (
		@(posedge clk) disable iff (rst) int'(i_frame_pos) < FRAME_LEN
	);

endmodule

`default_nettype wire

/* logic/slot_timing_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slot_timing_if;

	// one cycle pulses
	logic symb_head;
	logic slot_head;

	// delayed frame start, lines up with the counters restarting
	logic frame_start_q;

	// numbers, valid in the same cycle as the heads
	frame_timing_pkg::symb_num_t symb_num;
	frame_timing_pkg::slot_num_t slot_num;

	// symbol timer side
	modport src (
		output symb_head, slot_head, symb_num, slot_num, frame_start_q
	);

	// sub-slot tick divider only needs the slot restarts
	modport tick (
		input slot_head, frame_start_q
	);

	// output register stage
	modport out (
		input symb_head, slot_head, symb_num, slot_num, frame_start_q
	);

endinterface

`default_nettype wire

/* logic/frame_timing_pkg.sv */
`default_nettype none

package frame_timing_pkg;

	// ----------------------------------------------------------
	// sample domain widths
	// ----------------------------------------------------------

	// sample position inside one frame
	// 10 ms at 491.52 MHz still fits
	typedef logic [22:0] smp_cnt_t;

	// sample position inside one symbol, long cp included
	typedef logic [14:0] symb_len_t;

	// ----------------------------------------------------------
	// running numbers
	// ----------------------------------------------------------

	// symbol inside a slot, 0 to 13
	typedef logic [3:0] symb_num_t;

	// slot inside a frame
	typedef logic [7:0] slot_num_t;

	// free running, wraps at 1024
	typedef logic [9:0] frame_num_t;

	// two per frame
	typedef logic [10:0] half_frame_num_t;

	// sub-slot tick inside a slot
	typedef logic [4:0] tick_num_t;

	// normal cp numerology
	localparam int SYMB_PER_SLOT = 14;

endpackage

`default_nettype wire
